/* src/lite_mux_pkg.sv */
/*
 * AXI4-Lite write mux shared sizes and channel types
 */

package lite_mux_pkg;

  // --------------------------------------------------
  // Sizes
  // --------------------------------------------------
  // Requesting ports on the slave side
  localparam int unsigned NUM_PORTS = 4;
  // Outstanding writes per selection queue
  localparam int unsigned MAX_TRANS = 4;
  localparam int unsigned ADDR_W    = 32;
  localparam int unsigned DATA_W    = 32;
  localparam int unsigned STRB_W    = DATA_W / 8;
  // Port index width
  localparam int unsigned SEL_W     = $clog2(NUM_PORTS);
  // Queue pointer and fill count widths
  localparam int unsigned PTR_W     = $clog2(MAX_TRANS);
  localparam int unsigned CNT_W     = $clog2(MAX_TRANS + 1);

  // --------------------------------------------------
  // Types
  // --------------------------------------------------
  typedef logic [SEL_W-1:0] sel_t;

  // Write address channel
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [2:0]        prot;
  } aw_chan_t;

  // Write data channel
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } w_chan_t;

  // Write response channel
  typedef struct packed {
    logic [1:0] resp;
  } b_chan_t;

endpackage

/* src/lite_sel_if.sv */
/*
 * Selection queue access between mux control and a port-index queue
 */

`timescale 1ns/100ps

interface lite_sel_if import lite_mux_pkg::*; ();

  // Write side
  logic push;
  sel_t push_sel;
  logic full;
  // Read side
  logic pop;
  sel_t head_sel;
  logic empty;

  // Control pushes and pops, sees the flags and the head
  modport ctrl_mp (
    output push, push_sel, pop,
    input  full, head_sel, empty
  );

  // Queue side
  modport fifo_mp (
    input  push, push_sel, pop,
    output full, head_sel, empty
  );

endinterface

/* src/lite_rr_arbiter.sv */
/*
 * Round-robin arbiter for the AW channels of all slave ports
 * Holds a pending grant until it is taken
 */

`timescale 1ns/100ps

module lite_rr_arbiter import lite_mux_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic     [NUM_PORTS-1:0] req_valid_i,
  input  aw_chan_t [NUM_PORTS-1:0] req_aw_i,
  output logic     [NUM_PORTS-1:0] req_ready_o,
  output logic                     arb_valid_o,
  output aw_chan_t                 arb_aw_o,
  output sel_t                     arb_sel_o,
  input  logic                     arb_ready_i
);

  // Last granted port
  sel_t rr_ptr_q;
  // Pick held while waiting for arb_ready_i
  logic lock_q;
  sel_t lock_sel_q;
  // Fresh round-robin pick
  sel_t pick;

  // --------------------------------------------------
  // Next requester after the last grant
  // --------------------------------------------------
  always_comb begin
    int   idx;
    logic found;
    idx   = 0;
    found = 1'b0;
    pick  = rr_ptr_q;
    for (int k = 1; k <= NUM_PORTS; k++) begin
      idx = (int'(rr_ptr_q) + k) % NUM_PORTS;
      if (!found && req_valid_i[idx]) begin
        pick  = sel_t'(idx);
        found = 1'b1;
      end
    end
  end

  // Locked pick wins so a waiting request stays selected
  assign arb_sel_o   = lock_q ? lock_sel_q : pick;
  assign arb_valid_o = req_valid_i[arb_sel_o];
  assign arb_aw_o    = req_aw_i[arb_sel_o];

  // Ready only toward the selected port
  always_comb begin
    req_ready_o = '0;
    req_ready_o[arb_sel_o] = arb_valid_o & arb_ready_i;
  end

  // --------------------------------------------------
  // Lock and pointer update
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_ptr_q   <= sel_t'(NUM_PORTS - 1);
      lock_q     <= 1'b0;
      lock_sel_q <= '0;
    end else begin
      // Stalled grant stays put
      lock_q <= arb_valid_o & ~arb_ready_i;
      if (arb_valid_o && !arb_ready_i) begin
        lock_sel_q <= arb_sel_o;
      end
      // Pointer moves on completed grant only
      if (arb_valid_o && arb_ready_i) begin
        rr_ptr_q <= arb_sel_o;
      end
    end
  end

endmodule

/* src/lite_sel_fifo.sv */
/*
 * Circular queue of port indices, MAX_TRANS entries deep
 */

`timescale 1ns/100ps

module lite_sel_fifo import lite_mux_pkg::*; (
  input logic       clk_i,
  input logic       rst_n_i,
  lite_sel_if.fifo_mp sel
);

  sel_t             mem [MAX_TRANS];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  // Flags from the fill count
  assign sel.full  = (count_q == CNT_W'(MAX_TRANS));
  assign sel.empty = (count_q == '0);

  // Requests outside the legal range are dropped
  assign do_push = sel.push & ~sel.full;
  assign do_pop  = sel.pop & ~sel.empty;

  // Oldest entry
  assign sel.head_sel = mem[rd_ptr_q];

  // --------------------------------------------------
  // Pointers and count
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(MAX_TRANS - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(MAX_TRANS - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop keeps the count
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= sel.push_sel;
    end
  end

endmodule

/* src/lite_spill_reg.sv */
/*
 * Two-slot spill register, cuts the ready path at full throughput
 */

`timescale 1ns/100ps

module lite_spill_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  // Slot A takes new input, slot B holds a stalled output
  logic     a_full_q;
  logic     b_full_q;
  payload_t a_data_q;
  payload_t b_data_q;

  logic a_fill;
  logic a_drain;
  logic b_fill;
  logic b_drain;

  // --------------------------------------------------
  // Slot control
  // --------------------------------------------------
  assign a_fill  = valid_i & ready_o;
  // A empties whenever B is free
  assign a_drain = a_full_q & ~b_full_q;
  // A moves to B if downstream stalls
  assign b_fill  = a_drain & ~ready_i;
  assign b_drain = b_full_q & ready_i;

  // Occupancy only, no path from ready_i
  assign ready_o = ~a_full_q | ~b_full_q;
  assign valid_o = a_full_q | b_full_q;
  // B is always the older entry
  assign data_o  = b_full_q ? b_data_q : a_data_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill) begin
        a_full_q <= 1'b1;
      end else if (a_drain) begin
        a_full_q <= 1'b0;
      end
      if (b_fill) begin
        b_full_q <= 1'b1;
      end else if (b_drain) begin
        b_full_q <= 1'b0;
      end
    end
  end

  // Payload slots
  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

endmodule

/* src/lite_mux_ctrl.sv */
/*
 * Write mux control: AW valid lock, selection queue pushes and pops,
 * W selection by AW order and B routing by W order
 */

`timescale 1ns/100ps

module lite_mux_ctrl import lite_mux_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // Arbiter decision
  input  logic                    arb_valid_i,
  input  sel_t                    arb_sel_i,
  output logic                    arb_ready_o,
  // AW toward the spill register
  output logic                    aw_out_valid_o,
  input  logic                    aw_out_ready_i,
  // W from the slave ports
  input  logic    [NUM_PORTS-1:0] slv_w_valid_i,
  input  w_chan_t [NUM_PORTS-1:0] slv_w_i,
  output logic    [NUM_PORTS-1:0] slv_w_ready_o,
  // W toward the spill register
  output logic                    w_out_valid_o,
  output w_chan_t                 w_out_o,
  input  logic                    w_out_ready_i,
  // B routing
  input  logic                    mst_b_valid_i,
  output logic                    mst_b_ready_o,
  input  logic    [NUM_PORTS-1:0] slv_b_ready_i,
  output logic    [NUM_PORTS-1:0] slv_b_valid_o,
  // Selection queues
  lite_sel_if.ctrl_mp             w_sel,
  lite_sel_if.ctrl_mp             b_sel
);

  // Set once a grant sits in w_sel but AW has not gone out
  logic lock_q;
  logic lock_d;
  // W side may move
  logic w_en;

  // --------------------------------------------------
  // AW channel
  // --------------------------------------------------
  always_comb begin
    lock_d         = lock_q;
    aw_out_valid_o = 1'b0;
    arb_ready_o    = 1'b0;
    w_sel.push     = 1'b0;
    if (lock_q) begin
      // Index already queued, only finish the handshake
      aw_out_valid_o = 1'b1;
      if (aw_out_ready_i) begin
        arb_ready_o = 1'b1;
        lock_d      = 1'b0;
      end
    end else if (arb_valid_i && !w_sel.full) begin
      aw_out_valid_o = 1'b1;
      w_sel.push     = 1'b1;
      if (aw_out_ready_i) begin
        arb_ready_o = 1'b1;
      end else begin
        lock_d = 1'b1;
      end
    end
  end

  assign w_sel.push_sel = arb_sel_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lock_q <= 1'b0;
    end else begin
      lock_q <= lock_d;
    end
  end

  // --------------------------------------------------
  // W channel
  // --------------------------------------------------
  // Need a granted AW and room for the B index
  assign w_en          = ~w_sel.empty & ~b_sel.full;
  assign w_out_valid_o = w_en & slv_w_valid_i[w_sel.head_sel];
  assign w_out_o       = w_en ? slv_w_i[w_sel.head_sel] : '0;

  // Ready to head port only
  always_comb begin
    slv_w_ready_o = '0;
    slv_w_ready_o[w_sel.head_sel] = w_en & w_out_ready_i;
  end

  // W transfer moves the index from w_sel to b_sel
  assign w_sel.pop      = w_out_valid_o & w_out_ready_i;
  assign b_sel.push     = w_sel.pop;
  assign b_sel.push_sel = w_sel.head_sel;

  // --------------------------------------------------
  // B channel
  // --------------------------------------------------
  always_comb begin
    slv_b_valid_o = '0;
    slv_b_valid_o[b_sel.head_sel] = mst_b_valid_i & ~b_sel.empty;
  end

  assign mst_b_ready_o = ~b_sel.empty & slv_b_ready_i[b_sel.head_sel];
  assign b_sel.pop     = mst_b_valid_i & mst_b_ready_o;

endmodule

/* src/lite_mux.sv */
/*
 * AXI4-Lite write multiplexer, NUM_PORTS slave ports onto one master port
 * Round-robin AW, W in AW order, B routed back in order
 */

`timescale 1ns/100ps

module lite_mux import lite_mux_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // Slave ports
  input  logic     [NUM_PORTS-1:0] slv_aw_valid_i,
  input  aw_chan_t [NUM_PORTS-1:0] slv_aw_i,
  output logic     [NUM_PORTS-1:0] slv_aw_ready_o,
  input  logic     [NUM_PORTS-1:0] slv_w_valid_i,
  input  w_chan_t  [NUM_PORTS-1:0] slv_w_i,
  output logic     [NUM_PORTS-1:0] slv_w_ready_o,
  output logic     [NUM_PORTS-1:0] slv_b_valid_o,
  output b_chan_t  [NUM_PORTS-1:0] slv_b_o,
  input  logic     [NUM_PORTS-1:0] slv_b_ready_i,
  // Master port
  output logic                     mst_aw_valid_o,
  output aw_chan_t                 mst_aw_o,
  input  logic                     mst_aw_ready_i,
  output logic                     mst_w_valid_o,
  output w_chan_t                  mst_w_o,
  input  logic                     mst_w_ready_i,
  input  logic                     mst_b_valid_i,
  input  b_chan_t                  mst_b_i,
  output logic                     mst_b_ready_o
);

  // Arbiter to control
  logic     arb_valid;
  logic     arb_ready;
  aw_chan_t arb_aw;
  sel_t     arb_sel;
  // Control to spill registers
  logic     aw_out_valid;
  logic     aw_out_ready;
  logic     w_out_valid;
  logic     w_out_ready;
  w_chan_t  w_out;

  // AW grant order and W completion order
  lite_sel_if w_sel ();
  lite_sel_if b_sel ();

  // --------------------------------------------------
  // AW path
  // --------------------------------------------------
  lite_rr_arbiter i_aw_arbiter (
    .clk_i       ( clk_i          ),
    .rst_n_i     ( rst_n_i        ),
    .req_valid_i ( slv_aw_valid_i ),
    .req_aw_i    ( slv_aw_i       ),
    .req_ready_o ( slv_aw_ready_o ),
    .arb_valid_o ( arb_valid      ),
    .arb_aw_o    ( arb_aw         ),
    .arb_sel_o   ( arb_sel        ),
    .arb_ready_i ( arb_ready      )
  );

  lite_spill_reg #(
    .payload_t ( aw_chan_t )
  ) i_aw_spill_reg (
    .clk_i   ( clk_i          ),
    .rst_n_i ( rst_n_i        ),
    .valid_i ( aw_out_valid   ),
    .ready_o ( aw_out_ready   ),
    .data_i  ( arb_aw         ),
    .valid_o ( mst_aw_valid_o ),
    .ready_i ( mst_aw_ready_i ),
    .data_o  ( mst_aw_o       )
  );

  // Control and selection queues
  lite_mux_ctrl i_ctrl (
    .clk_i          ( clk_i         ),
    .rst_n_i        ( rst_n_i       ),
    .arb_valid_i    ( arb_valid     ),
    .arb_sel_i      ( arb_sel       ),
    .arb_ready_o    ( arb_ready     ),
    .aw_out_valid_o ( aw_out_valid  ),
    .aw_out_ready_i ( aw_out_ready  ),
    .slv_w_valid_i  ( slv_w_valid_i ),
    .slv_w_i        ( slv_w_i       ),
    .slv_w_ready_o  ( slv_w_ready_o ),
    .w_out_valid_o  ( w_out_valid   ),
    .w_out_o        ( w_out         ),
    .w_out_ready_i  ( w_out_ready   ),
    .mst_b_valid_i  ( mst_b_valid_i ),
    .mst_b_ready_o  ( mst_b_ready_o ),
    .slv_b_ready_i  ( slv_b_ready_i ),
    .slv_b_valid_o  ( slv_b_valid_o ),
    .w_sel          ( w_sel         ),
    .b_sel          ( b_sel         )
  );

  lite_sel_fifo i_w_sel_fifo (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .sel     ( w_sel   )
  );

  lite_sel_fifo i_b_sel_fifo (
    .clk_i   ( clk_i   ),
    .rst_n_i ( rst_n_i ),
    .sel     ( b_sel   )
  );

  // --------------------------------------------------
  // W and B paths
  // --------------------------------------------------
  lite_spill_reg #(
    .payload_t ( w_chan_t )
  ) i_w_spill_reg (
    .clk_i   ( clk_i         ),
    .rst_n_i ( rst_n_i       ),
    .valid_i ( w_out_valid   ),
    .ready_o ( w_out_ready   ),
    .data_i  ( w_out         ),
    .valid_o ( mst_w_valid_o ),
    .ready_i ( mst_w_ready_i ),
    .data_o  ( mst_w_o       )
  );

  // Same response to all ports, valid decides who takes it
  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_b_fanout
    assign slv_b_o[i] = mst_b_i;
  end

endmodule

/* testbench/lite_mux_checker.sv */
/*
 * Bound protocol checks on the write mux master outputs and slave routing
 */

`timescale 1ns/100ps

module lite_mux_checker import lite_mux_pkg::*; (
  input logic                 clk_i,
  input logic                 rst_n_i,
  input logic                 aw_valid_i,
  input logic                 aw_ready_i,
  input aw_chan_t             aw_i,
  input logic                 w_valid_i,
  input logic                 w_ready_i,
  input w_chan_t              w_i,
  input logic                 b_valid_i,
  input logic [NUM_PORTS-1:0] slv_b_valid_i,
  input logic [NUM_PORTS-1:0] slv_w_ready_i
);

  // Number of failed assertions, summed up by the testbench
  int unsigned assert_fails = 0;

  // Stalled master AW keeps valid and payload
  a_aw_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    aw_valid_i && !aw_ready_i |=> aw_valid_i && $stable(aw_i))
  else begin
    $error("master AW dropped or changed while stalled");
    assert_fails++;
  end

  // Same rule on master W
  a_w_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    w_valid_i && !w_ready_i |=> w_valid_i && $stable(w_i))
  else begin
    $error("master W dropped or changed while stalled");
    assert_fails++;
  end

  // A slave B only with a master B behind it
  a_b_valid_src: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    |slv_b_valid_i |-> b_valid_i)
  else begin
    $error("slave B valid without master B valid");
    assert_fails++;
  end

  // W taken from one port at most
  a_w_ready_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(slv_w_ready_i))
  else begin
    $error("more than one slave W ready");
    assert_fails++;
  end

endmodule

bind lite_mux lite_mux_checker i_lite_mux_checker (
  .clk_i         ( clk_i          ),
  .rst_n_i       ( rst_n_i        ),
  .aw_valid_i    ( mst_aw_valid_o ),
  .aw_ready_i    ( mst_aw_ready_i ),
  .aw_i          ( mst_aw_o       ),
  .w_valid_i     ( mst_w_valid_o  ),
  .w_ready_i     ( mst_w_ready_i  ),
  .w_i           ( mst_w_o        ),
  .b_valid_i     ( mst_b_valid_i  ),
  .slv_b_valid_i ( slv_b_valid_o  ),
  .slv_w_ready_i ( slv_w_ready_o  )
);

/* testbench/tb_lite_mux.sv */
/*
 * Testbench for the AXI4-Lite write mux: random writes from all ports,
 * master responder with random stalls, order and routing model
 */

`timescale 1ns/100ps

module tb_lite_mux import lite_mux_pkg::*; ();

  logic                     clk_i;
  logic                     rst_n_i;
  logic     [NUM_PORTS-1:0] slv_aw_valid_i;
  aw_chan_t [NUM_PORTS-1:0] slv_aw_i;
  logic     [NUM_PORTS-1:0] slv_aw_ready_o;
  logic     [NUM_PORTS-1:0] slv_w_valid_i;
  w_chan_t  [NUM_PORTS-1:0] slv_w_i;
  logic     [NUM_PORTS-1:0] slv_w_ready_o;
  logic     [NUM_PORTS-1:0] slv_b_valid_o;
  b_chan_t  [NUM_PORTS-1:0] slv_b_o;
  logic     [NUM_PORTS-1:0] slv_b_ready_i;
  logic                     mst_aw_valid_o;
  aw_chan_t                 mst_aw_o;
  logic                     mst_aw_ready_i;
  logic                     mst_w_valid_o;
  w_chan_t                  mst_w_o;
  logic                     mst_w_ready_i;
  logic                     mst_b_valid_i;
  b_chan_t                  mst_b_i;
  logic                     mst_b_ready_o;

  // --------------------------------------------------
  // Stimulus tables and model state
  // --------------------------------------------------
  logic [31:0] lfsr_q;
  // Per port table of 16 entries for up to 13 writes
  int unsigned n_wr      [NUM_PORTS];
  aw_chan_t    aw_tab    [NUM_PORTS][16];
  w_chan_t     w_tab     [NUM_PORTS][16];
  int unsigned w_rel     [NUM_PORTS][16];
  int unsigned aw_sent   [NUM_PORTS];
  int unsigned w_sent    [NUM_PORTS];
  int unsigned since_own [NUM_PORTS];
  logic [NUM_PORTS-1:0] aw_vld;
  logic [NUM_PORTS-1:0] w_vld;
  // Global write order as granted on the slave side
  sel_t        grant_port [NUM_PORTS*16];
  int unsigned grant_idx  [NUM_PORTS*16];
  // Responder view of master AWs
  logic [ADDR_W-1:0] mst_addr [NUM_PORTS*16];
  logic        b_vld;
  int unsigned n_grant;
  int unsigned aw_rx;
  int unsigned w_rx;
  int unsigned b_issued;
  int unsigned b_done;
  int unsigned total;
  int unsigned limit;
  int unsigned cycles;
  int unsigned value_errors;
  int unsigned other_errors;
  int unsigned assert_errors;

  lite_mux i_lite_mux (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] take_bits(input int unsigned n);
    logic [31:0] val;
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      val    = {val[30:0], lfsr_q[0]};
    end
    return val;
  endfunction

  // Responder answer from the address low bits
  function automatic b_chan_t resp_of(input logic [ADDR_W-1:0] addr);
    b_chan_t b;
    b.resp = addr[1:0];
    return b;
  endfunction

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic check_aw(input string name, input aw_chan_t got, input aw_chan_t exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s got addr %h prot %h, expected addr %h prot %h",
               $time, name, got.addr, got.prot, exp.addr, exp.prot);
      value_errors++;
    end
  endtask

  task automatic check_w(input string name, input w_chan_t got, input w_chan_t exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s got data %h strb %h, expected data %h strb %h",
               $time, name, got.data, got.strb, exp.data, exp.strb);
      value_errors++;
    end
  endtask

  task automatic check_b(input string name, input b_chan_t got, input b_chan_t exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s got resp %b, expected resp %b",
               $time, name, got.resp, exp.resp);
      value_errors++;
    end
  endtask

  task automatic check_flags(input string name, input logic [NUM_PORTS-1:0] got,
                             input logic [NUM_PORTS-1:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s got %b, expected %b", $time, name, got, exp);
      value_errors++;
    end
  endtask

  // --------------------------------------------------
  // Drive a short delay after the rising edge
  // --------------------------------------------------
  task automatic drive_inputs();
    for (int p = 0; p < NUM_PORTS; p++) begin
      // New AW mostly right away, held until taken
      if (!aw_vld[p] && aw_sent[p] < n_wr[p] && take_bits(2) != 0) begin
        aw_vld[p] = 1'b1;
      end
      slv_aw_valid_i[p] = aw_vld[p];
      slv_aw_i[p]       = aw_vld[p] ? aw_tab[p][aw_sent[p]] : '0;
      // W some cycles after its own AW
      if (!w_vld[p] && w_sent[p] < aw_sent[p] && cycles >= w_rel[p][w_sent[p]]) begin
        w_vld[p] = 1'b1;
      end
      slv_w_valid_i[p] = w_vld[p];
      slv_w_i[p]       = w_vld[p] ? w_tab[p][w_sent[p]] : '0;
      // Slow B acceptance
      slv_b_ready_i[p] = (take_bits(2) == 0);
    end
    mst_aw_ready_i = 1'(take_bits(1));
    mst_w_ready_i  = 1'(take_bits(1));
    // Responder answers once AW and W of a write arrived
    if (!b_vld && b_issued < aw_rx && b_issued < w_rx && take_bits(1)) begin
      b_vld = 1'b1;
    end
    mst_b_valid_i = b_vld;
    mst_b_i       = b_vld ? resp_of(mst_addr[b_issued]) : '0;
  endtask

  // --------------------------------------------------
  // Sample at the falling edge before the next rise
  // --------------------------------------------------
  task automatic sample_outputs();
    logic [NUM_PORTS-1:0] grant_vec;
    logic [NUM_PORTS-1:0] b_exp;
    sel_t                 owner;
    grant_vec = slv_aw_valid_i & slv_aw_ready_o;
    b_exp     = '0;
    owner     = grant_port[b_done];
    // Master AW against grant order and port table
    if (mst_aw_valid_o && mst_aw_ready_i) begin
      if (aw_rx >= n_grant) begin
        $display("Error at %0t ns: master AW without a granted slave AW", $time);
        other_errors++;
      end else begin
        check_aw("mst_aw_o", mst_aw_o, aw_tab[grant_port[aw_rx]][grant_idx[aw_rx]]);
        mst_addr[aw_rx] = mst_aw_o.addr;
        aw_rx++;
      end
    end
    // Master W in the same order
    if (mst_w_valid_o && mst_w_ready_i) begin
      if (w_rx >= n_grant) begin
        $display("Error at %0t ns: master W without a granted slave AW", $time);
        other_errors++;
      end else begin
        check_w("mst_w_o", mst_w_o, w_tab[grant_port[w_rx]][grant_idx[w_rx]]);
        w_rx++;
      end
    end
    // B valid only toward the oldest open write
    if (mst_b_valid_i) begin
      b_exp[owner] = 1'b1;
      // Master B ready follows the owner's ready
      check_flags("mst_b_ready_o", NUM_PORTS'(mst_b_ready_o),
                  NUM_PORTS'(slv_b_ready_i[owner]));
    end
    check_flags("slv_b_valid_o", slv_b_valid_o, b_exp);
    if (mst_b_valid_i && mst_b_ready_o) begin
      check_b("slv_b_o", slv_b_o[owner], resp_of(aw_tab[owner][grant_idx[b_done]].addr));
      b_vld = 1'b0;
      b_issued++;
      b_done++;
    end
    if ($countones(grant_vec) > 1) begin
      $display("Error at %0t ns: more than one slave AW taken in a cycle", $time);
      other_errors++;
    end
    for (int p = 0; p < NUM_PORTS; p++) begin
      // Fairness counts other grants while this port waits
      if (!slv_aw_valid_i[p]) begin
        since_own[p] = 0;
      end else if (grant_vec[p]) begin
        if (since_own[p] > NUM_PORTS - 1) begin
          $display("Error at %0t ns: port %0d waited through %0d other grants",
                   $time, p, since_own[p]);
          other_errors++;
        end
        since_own[p] = 0;
      end else if (grant_vec != '0) begin
        since_own[p]++;
      end
      if (grant_vec[p]) begin
        grant_port[n_grant]    = sel_t'(p);
        grant_idx[n_grant]     = aw_sent[p];
        w_rel[p][aw_sent[p]]   = cycles + 1 + take_bits(2);
        aw_vld[p]              = 1'b0;
        aw_sent[p]++;
        n_grant++;
      end
      if (slv_w_valid_i[p] && slv_w_ready_o[p]) begin
        w_vld[p] = 1'b0;
        w_sent[p]++;
      end
    end
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    lfsr_q         = 32'haf86_a734;
    rst_n_i        = 1'b0;
    slv_aw_valid_i = '0;
    slv_aw_i       = '0;
    slv_w_valid_i  = '0;
    slv_w_i        = '0;
    slv_b_ready_i  = '0;
    mst_aw_ready_i = 1'b0;
    mst_w_ready_i  = 1'b0;
    mst_b_valid_i  = 1'b0;
    mst_b_i        = '0;
    aw_vld         = '0;
    w_vld          = '0;
    b_vld          = 1'b0;
    n_grant        = 0;
    aw_rx          = 0;
    w_rx           = 0;
    b_issued       = 0;
    b_done         = 0;
    total          = 0;
    cycles         = 0;
    value_errors   = 0;
    other_errors   = 0;
    // Port index in addr[31:30], per port count below
    for (int p = 0; p < NUM_PORTS; p++) begin
      n_wr[p]      = 6 + take_bits(3);
      aw_sent[p]   = 0;
      w_sent[p]    = 0;
      since_own[p] = 0;
      total        += n_wr[p];
      for (int k = 0; k < 16; k++) begin
        aw_tab[p][k].addr = {sel_t'(p), (ADDR_W - SEL_W)'(k)};
        aw_tab[p][k].prot = 3'(take_bits(3));
        w_tab[p][k].data  = take_bits(32);
        w_tab[p][k].strb  = STRB_W'(take_bits(4));
        w_rel[p][k]       = 0;
      end
    end
    limit = 40 * total;

    repeat (16) @(posedge clk_i);
    #2 rst_n_i = 1'b1;
    // Idle outputs right after reset
    @(negedge clk_i);
    check_flags("mst_aw_valid_o", NUM_PORTS'(mst_aw_valid_o), '0);
    check_flags("mst_w_valid_o", NUM_PORTS'(mst_w_valid_o), '0);
    check_flags("mst_b_ready_o", NUM_PORTS'(mst_b_ready_o), '0);
    check_flags("slv_aw_ready_o", slv_aw_ready_o, '0);
    check_flags("slv_w_ready_o", slv_w_ready_o, '0);
    check_flags("slv_b_valid_o", slv_b_valid_o, '0);

    while (b_done < total && cycles < limit) begin
      @(posedge clk_i);
      #2;
      drive_inputs();
      @(negedge clk_i);
      sample_outputs();
      cycles++;
    end

    // --------------------------------------------------
    // Drain check and result
    // --------------------------------------------------
    if (b_done < total) begin
      $display("Error: run stopped after %0d cycles with %0d of %0d writes done",
               cycles, b_done, total);
      other_errors++;
    end
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (aw_sent[p] != n_wr[p] || w_sent[p] != n_wr[p]) begin
        $display("Error: port %0d sent %0d AW and %0d W of %0d writes",
                 p, aw_sent[p], w_sent[p], n_wr[p]);
        other_errors++;
      end
    end
    if (aw_rx != total || w_rx != total) begin
      $display("Error: master saw %0d AW and %0d W of %0d writes", aw_rx, w_rx, total);
      other_errors++;
    end
    assert_errors = i_lite_mux.i_lite_mux_checker.assert_fails;
    $display("Writes %0d, value errors %0d, other errors %0d, assertion failures %0d",
             total, value_errors, other_errors, assert_errors);
    if (value_errors == 0 && other_errors == 0 && assert_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
src/lite_mux_pkg.sv
src/lite_sel_if.sv
src/lite_rr_arbiter.sv
src/lite_sel_fifo.sv
src/lite_spill_reg.sv
src/lite_mux_ctrl.sv
src/lite_mux.sv
testbench/lite_mux_checker.sv
testbench/tb_lite_mux.sv
